/* src/rv32i_pkg.sv */
`default_nettype none

package rv32i_pkg;

    // one machine word, used for pcs and result values
    typedef logic [31:0] word_t;

    // architectural register index x0..x31
    typedef logic [4:0] reg_idx_t;

    // retirement order number
    // wide enough never to wrap in practice
    typedef logic [63:0] order_t;

endpackage : rv32i_pkg

`default_nettype wire

/* src/rob_pkg.sv */
`default_nettype none

package rob_pkg;

    // instructions dispatched and inspected for commit per cycle
    localparam int DEFAULT_SS = 2;

    // writeback ports on the common data bus
    localparam int DEFAULT_CDB = 2;

    // must stay a power of two so the pointers wrap for free
    localparam int DEFAULT_ROB_DEPTH = 8;

endpackage : rob_pkg

`default_nettype wire

/* src/rob_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_queue #(
    parameter int SS        = 2,
    parameter int CDB       = 2,
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    // dispatch group, written at the tail
    input  logic                         dispatch_valid,
    input  rv32i_pkg::word_t             dispatch_pc            [SS],
    input  rv32i_pkg::reg_idx_t          dispatch_rd            [SS],
    input  logic                         dispatch_is_branch     [SS],
    input  logic                         dispatch_predict_taken [SS],
    output logic [$clog2(ROB_DEPTH)-1:0] dispatch_rob_id        [SS],
    output logic                         rob_full,
    // common data bus writeback
    input  logic                         cdb_valid              [CDB],
    input  logic [$clog2(ROB_DEPTH)-1:0] cdb_rob_id             [CDB],
    input  rv32i_pkg::word_t             cdb_value              [CDB],
    input  logic                         cdb_taken              [CDB],
    // from the commit stage
    input  logic [$clog2(SS+1)-1:0]      pop_count,
    input  logic                         flush,
    // oldest SS entries
    output logic                         head_valid             [SS],
    output logic                         head_done              [SS],
    output logic                         head_mispredict        [SS],
    output logic                         head_is_branch         [SS],
    output logic                         head_taken             [SS],
    output rv32i_pkg::word_t             head_pc                [SS],
    output rv32i_pkg::reg_idx_t          head_rd                [SS],
    output rv32i_pkg::word_t             head_value             [SS]
);

    import rv32i_pkg::*;

    localparam int IDX_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = IDX_W + 1;

    // control state per entry
    logic     entry_valid      [ROB_DEPTH];
    logic     entry_done       [ROB_DEPTH];

    // payload per entry
    logic     entry_is_branch  [ROB_DEPTH];
    logic     entry_predict    [ROB_DEPTH];
    logic     entry_mispredict [ROB_DEPTH];
    logic     entry_taken      [ROB_DEPTH];
    word_t    entry_pc         [ROB_DEPTH];
    reg_idx_t entry_rd         [ROB_DEPTH];
    word_t    entry_value      [ROB_DEPTH];

    logic [IDX_W-1:0] head;
    logic [IDX_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic [IDX_W-1:0] head_idx [SS];
    logic             dispatch_accept;
    logic [CNT_W-1:0] push_count;

    // full as soon as a whole group no longer fits
    assign rob_full = count > CNT_W'(ROB_DEPTH - SS);

    assign dispatch_accept = dispatch_valid && !rob_full && !flush;
    assign push_count      = dispatch_accept ? CNT_W'(SS) : '0;

    // ids wrap around the power-of-two depth
    always_comb begin
        for (int i = 0; i < SS; i++) begin
            dispatch_rob_id[i] = tail + IDX_W'(i);
            head_idx[i]        = head + IDX_W'(i);
        end
    end

    always_comb begin
        for (int i = 0; i < SS; i++) begin
            head_valid[i]      = entry_valid[head_idx[i]];
            head_done[i]       = entry_done[head_idx[i]];
            head_mispredict[i] = entry_mispredict[head_idx[i]];
            head_is_branch[i]  = entry_is_branch[head_idx[i]];
            head_taken[i]      = entry_taken[head_idx[i]];
            head_pc[i]         = entry_pc[head_idx[i]];
            head_rd[i]         = entry_rd[head_idx[i]];
            head_value[i]      = entry_value[head_idx[i]];
        end
    end

    // pointers, occupancy and per-entry status
    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int e = 0; e < ROB_DEPTH; e++) begin
                entry_valid[e] <= 1'b0;
                entry_done[e]  <= 1'b0;
            end
        end else if (flush) begin
            // mispredict at commit drops everything still in flight
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int e = 0; e < ROB_DEPTH; e++) begin
                entry_valid[e] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < SS; i++) begin
                if (i < int'(pop_count)) begin
                    entry_valid[head_idx[i]] <= 1'b0;
                end
            end
            // new entries never alias live ones, so order against pop is free
            if (dispatch_accept) begin
                for (int i = 0; i < SS; i++) begin
                    entry_valid[dispatch_rob_id[i]] <= 1'b1;
                    entry_done[dispatch_rob_id[i]]  <= 1'b0;
                end
            end
            for (int p = 0; p < CDB; p++) begin
                if (cdb_valid[p]) begin
                    entry_done[cdb_rob_id[p]] <= 1'b1;
                end
            end
            head  <= head + IDX_W'(pop_count);
            tail  <= dispatch_accept ? tail + IDX_W'(SS) : tail;
            count <= count + push_count - CNT_W'(pop_count);
        end
    end

    // instruction payload and results
    always_ff @(posedge clk) begin
        if (dispatch_accept) begin
            for (int i = 0; i < SS; i++) begin
                entry_pc[dispatch_rob_id[i]]        <= dispatch_pc[i];
                entry_rd[dispatch_rob_id[i]]        <= dispatch_rd[i];
                entry_is_branch[dispatch_rob_id[i]] <= dispatch_is_branch[i];
                entry_predict[dispatch_rob_id[i]]   <= dispatch_predict_taken[i];
            end
        end
        for (int p = 0; p < CDB; p++) begin
            if (cdb_valid[p]) begin
                entry_value[cdb_rob_id[p]] <= cdb_value[p];
                // resolve against the prediction made at dispatch
                entry_taken[cdb_rob_id[p]] <= entry_is_branch[cdb_rob_id[p]] && cdb_taken[p];
                entry_mispredict[cdb_rob_id[p]] <= entry_is_branch[cdb_rob_id[p]] &&
                    (cdb_taken[p] != entry_predict[cdb_rob_id[p]]);
            end
        end
    end

endmodule : rob_queue

`default_nettype wire

/* src/rob_commit.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_commit #(
    parameter int SS = 2
) (
    input  logic                    clk,
    input  logic                    reset,
    // oldest SS entries of the queue
    input  logic                    head_valid      [SS],
    input  logic                    head_done       [SS],
    input  logic                    head_mispredict [SS],
    input  logic                    head_is_branch  [SS],
    input  logic                    head_taken      [SS],
    input  rv32i_pkg::word_t        head_pc         [SS],
    input  rv32i_pkg::reg_idx_t     head_rd         [SS],
    input  rv32i_pkg::word_t        head_value      [SS],
    // back to the queue
    output logic [$clog2(SS+1)-1:0] pop_count,
    output logic                    flush,
    // retirement
    output logic                    commit_valid    [SS],
    output rv32i_pkg::word_t        commit_pc       [SS],
    output rv32i_pkg::reg_idx_t     commit_rd       [SS],
    output rv32i_pkg::word_t        commit_value    [SS],
    output rv32i_pkg::word_t        commit_next_pc  [SS],
    output rv32i_pkg::order_t       commit_order    [SS]
);

    import rv32i_pkg::*;

    localparam int CW = $clog2(SS + 1);

    order_t order_count;

    // retire the leading run of done entries, stopping after a mispredict
    always_comb begin
        logic          chain;
        logic [CW-1:0] n;
        chain = 1'b1;
        n     = '0;
        flush = 1'b0;
        for (int i = 0; i < SS; i++) begin
            commit_valid[i] = chain && head_valid[i] && head_done[i];
            commit_order[i] = order_count + order_t'(n);
            if (commit_valid[i]) begin
                n = n + CW'(1);
            end
            flush = flush || (commit_valid[i] && head_mispredict[i]);
            // younger lanes wait for a lane that retired cleanly
            chain = commit_valid[i] && !head_mispredict[i];
        end
        pop_count = n;
    end

    always_comb begin
        for (int i = 0; i < SS; i++) begin
            commit_pc[i]    = head_pc[i];
            commit_rd[i]    = head_rd[i];
            commit_value[i] = head_value[i];
            // a taken branch carries its target in the result value
            if (head_is_branch[i] && head_taken[i]) begin
                commit_next_pc[i] = head_value[i];
            end else begin
                commit_next_pc[i] = head_pc[i] + 32'd4;
            end
        end
    end

    // keeps counting through flushes
    always_ff @(posedge clk) begin
        if (reset) begin
            order_count <= '0;
        end else begin
            order_count <= order_count + order_t'(pop_count);
        end
    end

endmodule : rob_commit

`default_nettype wire

/* src/rob.sv */
`timescale 1ns/1ps
`default_nettype none

module rob #(
    parameter int SS        = rob_pkg::DEFAULT_SS,
    parameter int CDB       = rob_pkg::DEFAULT_CDB,
    parameter int ROB_DEPTH = rob_pkg::DEFAULT_ROB_DEPTH
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         dispatch_valid,
    input  rv32i_pkg::word_t             dispatch_pc            [SS],
    input  rv32i_pkg::reg_idx_t          dispatch_rd            [SS],
    input  logic                         dispatch_is_branch     [SS],
    input  logic                         dispatch_predict_taken [SS],
    output logic [$clog2(ROB_DEPTH)-1:0] dispatch_rob_id        [SS],
    output logic                         rob_full,
    input  logic                         cdb_valid              [CDB],
    input  logic [$clog2(ROB_DEPTH)-1:0] cdb_rob_id             [CDB],
    input  rv32i_pkg::word_t             cdb_value              [CDB],
    input  logic                         cdb_taken              [CDB],
    output logic                         commit_valid           [SS],
    output rv32i_pkg::word_t             commit_pc              [SS],
    output rv32i_pkg::reg_idx_t          commit_rd              [SS],
    output rv32i_pkg::word_t             commit_value           [SS],
    output rv32i_pkg::word_t             commit_next_pc         [SS],
    output rv32i_pkg::order_t            commit_order           [SS],
    output logic                         flush
);

    import rv32i_pkg::*;

    // head window from queue to commit stage
    logic                   head_valid      [SS];
    logic                   head_done       [SS];
    logic                   head_mispredict [SS];
    logic                   head_is_branch  [SS];
    logic                   head_taken      [SS];
    word_t                  head_pc         [SS];
    reg_idx_t               head_rd         [SS];
    word_t                  head_value      [SS];
    logic [$clog2(SS+1)-1:0] pop_count;

    rob_queue #(
        .SS        (SS),
        .CDB       (CDB),
        .ROB_DEPTH (ROB_DEPTH)
    ) u_queue (
        .clk                    (clk),
        .reset                  (reset),
        .dispatch_valid         (dispatch_valid),
        .dispatch_pc            (dispatch_pc),
        .dispatch_rd            (dispatch_rd),
        .dispatch_is_branch     (dispatch_is_branch),
        .dispatch_predict_taken (dispatch_predict_taken),
        .dispatch_rob_id        (dispatch_rob_id),
        .rob_full               (rob_full),
        .cdb_valid              (cdb_valid),
        .cdb_rob_id             (cdb_rob_id),
        .cdb_value              (cdb_value),
        .cdb_taken              (cdb_taken),
        .pop_count              (pop_count),
        .flush                  (flush),
        .head_valid             (head_valid),
        .head_done              (head_done),
        .head_mispredict        (head_mispredict),
        .head_is_branch         (head_is_branch),
        .head_taken             (head_taken),
        .head_pc                (head_pc),
        .head_rd                (head_rd),
        .head_value             (head_value)
    );

    rob_commit #(
        .SS (SS)
    ) u_commit (
        .clk             (clk),
        .reset           (reset),
        .head_valid      (head_valid),
        .head_done       (head_done),
        .head_mispredict (head_mispredict),
        .head_is_branch  (head_is_branch),
        .head_taken      (head_taken),
        .head_pc         (head_pc),
        .head_rd         (head_rd),
        .head_value      (head_value),
        .pop_count       (pop_count),
        .flush           (flush),
        .commit_valid    (commit_valid),
        .commit_pc       (commit_pc),
        .commit_rd       (commit_rd),
        .commit_value    (commit_value),
        .commit_next_pc  (commit_next_pc),
        .commit_order    (commit_order)
    );

endmodule : rob

`default_nettype wire

/* bench/rob_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_checker #(
    parameter int SS        = 2,
    parameter int ROB_DEPTH = 8
) (
    input logic                         clk,
    input logic                         reset,
    input logic                         dispatch_valid,
    input logic [$clog2(ROB_DEPTH)-1:0] dispatch_rob_id [SS],
    input logic                         rob_full,
    input logic                         commit_valid    [SS],
    input logic                         flush
);

    int   fail_count = 0;
    logic commit_any;
    logic lanes_contiguous;

    always_comb begin
        commit_any       = 1'b0;
        lanes_contiguous = 1'b1;
        for (int i = 0; i < SS; i++) begin
            commit_any = commit_any || commit_valid[i];
        end
        for (int i = 1; i < SS; i++) begin
            // lane i may only retire behind lane i-1
            if (commit_valid[i] && !commit_valid[i-1]) begin
                lanes_contiguous = 1'b0;
            end
        end
    end

    // a flush only comes from a retiring mispredicted branch
    flush_with_commit: assert property (
        @(posedge clk) disable iff (reset) flush |-> commit_any
    ) else begin
        fail_count++;
        $error("flush high with no committing lane");
    end

    commit_contiguous: assert property (
        @(posedge clk) disable iff (reset) lanes_contiguous
    ) else begin
        fail_count++;
        $error("commit_valid lanes are not contiguous from lane 0");
    end

    reset_quiet: assert property (
        @(posedge clk) reset |=> (!rob_full && !commit_any)
    ) else begin
        fail_count++;
        $error("rob_full or commit_valid high right after reset");
    end

    // tail holds while the buffer refuses a group
    full_blocks_dispatch: assert property (
        @(posedge clk) disable iff (reset)
        (dispatch_valid && rob_full && !flush) |=> $stable(dispatch_rob_id[0])
    ) else begin
        fail_count++;
        $error("dispatch accepted while rob_full was high");
    end

endmodule : rob_checker

bind rob rob_checker #(
    .SS        (SS),
    .ROB_DEPTH (ROB_DEPTH)
) u_checker (
    .clk             (clk),
    .reset           (reset),
    .dispatch_valid  (dispatch_valid),
    .dispatch_rob_id (dispatch_rob_id),
    .rob_full        (rob_full),
    .commit_valid    (commit_valid),
    .flush           (flush)
);

`default_nettype wire

/* bench/tb_rob.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rob;

    import rv32i_pkg::*;
    import rob_pkg::*;

    localparam int SS             = DEFAULT_SS;
    localparam int CDB            = DEFAULT_CDB;
    localparam int ROB_DEPTH      = DEFAULT_ROB_DEPTH;
    localparam int IDX_W          = $clog2(ROB_DEPTH);
    localparam int RANDOM_GROUPS  = 60;
    localparam int FULL_GROUPS    = ROB_DEPTH / SS + 1;
    localparam int TIMEOUT_CYCLES = (RANDOM_GROUPS + FULL_GROUPS) * ROB_DEPTH * 40 + 200;
    localparam int WB_NONE        = 0;
    localparam int WB_RANDOM      = 1;
    localparam int WB_OLDEST      = 2;

    typedef struct packed {
        logic [IDX_W-1:0] id;
        word_t            pc;
        reg_idx_t         rd;
        logic             is_branch;
        logic             predict;
        logic             done;
        logic             taken;
        word_t            value;
    } model_entry_t;

    logic             clk;
    logic             reset;
    logic             dispatch_valid;
    word_t            dispatch_pc            [SS];
    reg_idx_t         dispatch_rd            [SS];
    logic             dispatch_is_branch     [SS];
    logic             dispatch_predict_taken [SS];
    logic [IDX_W-1:0] dispatch_rob_id        [SS];
    logic             rob_full;
    logic             cdb_valid              [CDB];
    logic [IDX_W-1:0] cdb_rob_id             [CDB];
    word_t            cdb_value              [CDB];
    logic             cdb_taken              [CDB];
    logic             commit_valid           [SS];
    word_t            commit_pc              [SS];
    reg_idx_t         commit_rd              [SS];
    word_t            commit_value           [SS];
    word_t            commit_next_pc         [SS];
    order_t           commit_order           [SS];
    logic             flush;

    // program-order model of the live entries
    model_entry_t model_q [$];
    order_t       model_order  = '0;
    int           model_tail   = 0;
    int           groups_left  = 0;
    int           value_errors = 0;
    int           other_errors = 0;
    int           dual_commits = 0;
    int           flush_count  = 0;
    int           stall_cycles = 0;
    bit           accepted     = 1'b0;
    bit           full_seen    = 1'b0;
    word_t        next_pc      = 32'h0000_1000;
    logic [31:0]  lcg_state    = 32'h5808;
    string        test_name    = "reset";

    rob #(
        .SS        (SS),
        .CDB       (CDB),
        .ROB_DEPTH (ROB_DEPTH)
    ) u_dut (
        .clk                    (clk),
        .reset                  (reset),
        .dispatch_valid         (dispatch_valid),
        .dispatch_pc            (dispatch_pc),
        .dispatch_rd            (dispatch_rd),
        .dispatch_is_branch     (dispatch_is_branch),
        .dispatch_predict_taken (dispatch_predict_taken),
        .dispatch_rob_id        (dispatch_rob_id),
        .rob_full               (rob_full),
        .cdb_valid              (cdb_valid),
        .cdb_rob_id             (cdb_rob_id),
        .cdb_value              (cdb_value),
        .cdb_taken              (cdb_taken),
        .commit_valid           (commit_valid),
        .commit_pc              (commit_pc),
        .commit_rd              (commit_rd),
        .commit_value           (commit_value),
        .commit_next_pc         (commit_next_pc),
        .commit_order           (commit_order),
        .flush                  (flush)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_random() >> 16) % n;
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        value_errors++;
        $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
                 test_name, what, expected, actual);
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("Error [%s]: %s", test_name, what);
    endtask

    // a refused group is held until the buffer takes it
    task automatic drive_dispatch(input bit eager, input bit with_branches);
        if (dispatch_valid && !accepted) begin
            dispatch_valid = 1'b1;
        end else if (groups_left > 0 && (eager || rand_below(4) != 0)) begin
            for (int i = 0; i < SS; i++) begin
                dispatch_pc[i]            = next_pc;
                next_pc                   = next_pc + 32'd4;
                dispatch_rd[i]            = reg_idx_t'(rand_below(32));
                dispatch_is_branch[i]     = with_branches && (rand_below(4) == 0);
                dispatch_predict_taken[i] = rand_below(2) == 1;
            end
            dispatch_valid = 1'b1;
            groups_left--;
        end else begin
            dispatch_valid = 1'b0;
        end
    endtask

    task automatic drive_writebacks(input int mode);
        model_entry_t e;
        int           cand [$];
        int           want;
        int           pick;
        for (int p = 0; p < CDB; p++) begin
            cdb_valid[p]  = 1'b0;
            cdb_rob_id[p] = '0;
            cdb_value[p]  = '0;
            cdb_taken[p]  = 1'b0;
        end
        for (int k = 0; k < model_q.size(); k++) begin
            e = model_q[k];
            if (!e.done) begin
                cand.push_back(k);
            end
        end
        want = (mode == WB_NONE) ? 0 : (mode == WB_OLDEST) ? CDB : rand_below(CDB + 1);
        for (int p = 0; p < want && cand.size() > 0; p++) begin
            pick = (mode == WB_OLDEST) ? 0 : rand_below(cand.size());
            e    = model_q[cand[pick]];
            cand.delete(pick);
            cdb_valid[p]  = 1'b1;
            cdb_rob_id[p] = e.id;
            cdb_taken[p]  = e.is_branch && (rand_below(2) == 1);
            // a taken branch returns its word-aligned target
            cdb_value[p]  = cdb_taken[p] ? (next_random() & 32'hFFFF_FFFC) : next_random();
        end
    endtask

    task automatic apply_writebacks();
        model_entry_t e;
        for (int p = 0; p < CDB; p++) begin
            if (cdb_valid[p]) begin
                for (int k = 0; k < model_q.size(); k++) begin
                    e = model_q[k];
                    if (e.id == cdb_rob_id[p]) begin
                        e.done     = 1'b1;
                        e.value    = cdb_value[p];
                        e.taken    = cdb_taken[p];
                        model_q[k] = e;
                    end
                end
            end
        end
    endtask

    // compare this cycle's outputs with the model, then advance it past the edge
    task automatic check_cycle();
        model_entry_t     e;
        logic             chain;
        logic             exp_valid;
        logic             exp_flush;
        logic             exp_full;
        logic             mispredict;
        logic [IDX_W-1:0] exp_id;
        word_t            exp_next;
        int               n;
        chain     = 1'b1;
        exp_flush = 1'b0;
        n         = 0;
        // full when a whole group no longer has free slots
        exp_full  = (ROB_DEPTH - model_q.size()) < SS;
        for (int i = 0; i < SS; i++) begin
            e = '0;
            if (i < model_q.size()) begin
                e = model_q[i];
            end
            exp_valid = chain && (i < model_q.size()) && e.done;
            assert (commit_valid[i] == exp_valid) else
                report_mismatch($sformatf("commit_valid[%0d]", i), 64'(exp_valid),
                                64'(commit_valid[i]));
            if (exp_valid) begin
                mispredict = e.is_branch && (e.taken != e.predict);
                exp_next   = (e.is_branch && e.taken) ? e.value : e.pc + 32'd4;
                if (commit_valid[i]) begin
                    assert (commit_pc[i] == e.pc) else
                        report_mismatch("commit_pc", 64'(e.pc), 64'(commit_pc[i]));
                    assert (commit_rd[i] == e.rd) else
                        report_mismatch("commit_rd", 64'(e.rd), 64'(commit_rd[i]));
                    assert (commit_value[i] == e.value) else
                        report_mismatch("commit_value", 64'(e.value), 64'(commit_value[i]));
                    assert (commit_next_pc[i] == exp_next) else
                        report_mismatch("commit_next_pc", 64'(exp_next), 64'(commit_next_pc[i]));
                    assert (commit_order[i] == model_order + order_t'(n)) else
                        report_mismatch("commit_order", model_order + order_t'(n),
                                        commit_order[i]);
                end
                n++;
                exp_flush = exp_flush || mispredict;
                chain     = !mispredict;
            end else begin
                chain = 1'b0;
            end
        end
        assert (flush == exp_flush) else
            report_mismatch("flush", 64'(exp_flush), 64'(flush));
        assert (rob_full == exp_full) else
            report_mismatch("rob_full", 64'(exp_full), 64'(rob_full));
        for (int i = 0; i < SS; i++) begin
            exp_id = IDX_W'(model_tail + i);
            assert (dispatch_rob_id[i] == exp_id) else
                report_mismatch($sformatf("dispatch_rob_id[%0d]", i), 64'(exp_id),
                                64'(dispatch_rob_id[i]));
        end
        if (exp_full) begin
            full_seen = 1'b1;
        end
        if (n == SS) begin
            dual_commits++;
        end
        if (exp_flush) begin
            flush_count++;
        end
        apply_writebacks();
        for (int k = 0; k < n; k++) begin
            void'(model_q.pop_front());
        end
        model_order = model_order + order_t'(n);
        accepted    = dispatch_valid && !exp_full && !exp_flush;
        if (exp_flush) begin
            model_q.delete();
            model_tail = 0;
        end else if (accepted) begin
            for (int i = 0; i < SS; i++) begin
                e           = '0;
                e.id        = IDX_W'(model_tail + i);
                e.pc        = dispatch_pc[i];
                e.rd        = dispatch_rd[i];
                e.is_branch = dispatch_is_branch[i];
                e.predict   = dispatch_predict_taken[i];
                model_q.push_back(e);
            end
            model_tail = (model_tail + SS) % ROB_DEPTH;
        end
    endtask

    task automatic run_until_drained(input bit eager, input bit with_branches,
                                     input int wb_mode);
        bit busy;
        busy = 1'b1;
        while (busy) begin
            @(posedge clk);
            #2;
            drive_dispatch(eager, with_branches);
            drive_writebacks(wb_mode);
            busy = groups_left > 0 || dispatch_valid || model_q.size() > 0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            check_cycle();
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("run did not finish within %0d cycles, the buffer appears stuck",
                 TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int checker_errors;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        for (int i = 0; i < SS; i++) begin
            dispatch_pc[i]            = '0;
            dispatch_rd[i]            = '0;
            dispatch_is_branch[i]     = 1'b0;
            dispatch_predict_taken[i] = 1'b0;
        end
        drive_writebacks(WB_NONE);
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        // out-of-order completion with branches and flushes
        test_name   = "random_ooo";
        groups_left = RANDOM_GROUPS;
        run_until_drained(1'b0, 1'b1, WB_RANDOM);

        // fill without writeback and keep a group waiting
        test_name   = "full_backpressure";
        groups_left = FULL_GROUPS;
        while (stall_cycles < 4) begin
            @(posedge clk);
            #2;
            drive_dispatch(1'b1, 1'b0);
            drive_writebacks(WB_NONE);
            if (rob_full && dispatch_valid) begin
                stall_cycles++;
            end
        end

        // both ports complete the two oldest entries each cycle
        test_name = "dual_writeback";
        run_until_drained(1'b1, 1'b0, WB_OLDEST);
        @(posedge clk);
        #2;

        test_name = "coverage";
        assert (flush_count > 0) else report_failure("no mispredicted branch reached commit");
        assert (dual_commits > 0) else report_failure("no cycle committed two entries at once");
        assert (full_seen) else report_failure("rob_full never rose");

        checker_errors = u_dut.u_checker.fail_count;
        $display("error counts: value %0d, other %0d, checker %0d",
                 value_errors, other_errors, checker_errors);
        if (value_errors + other_errors + checker_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_rob

`default_nettype wire

/* rob.f */
src/rv32i_pkg.sv
src/rob_pkg.sv
src/rob_queue.sv
src/rob_commit.sv
src/rob.sv
bench/rob_checker.sv
bench/tb_rob.sv

/* Makefile */
# Verilator build and run for the reorder buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_rob
FILELIST  ?= rob.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_FLAGS ?= +verilator+error+limit+1000
FAIL_MSG  ?= Simulation failed

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@status=0; ./$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1 || status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi; \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
